//--- rtl/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

	localparam int addr_bits = 15;
	localparam int data_bits = 8;
	localparam int frame_bits = 1 + addr_bits + data_bits;
	localparam int sck_half = 4; // One SPI bit is 2*(sck_half+1) clocks.
	localparam int queue_depth = 4;

	localparam int half_cnt_bits = $clog2(sck_half + 1);
	localparam int bit_cnt_bits = $clog2(frame_bits + 1);
	localparam int ptr_bits = $clog2(queue_depth);
	localparam int count_bits = $clog2(queue_depth + 1);

	localparam logic [31:0] reg_cmd = 32'h0;
	localparam logic [31:0] reg_status = 32'h4;
	localparam logic [31:0] reg_rdata = 32'h8;

	typedef struct packed {
		logic rw; // High for a read frame.
		logic [addr_bits-1:0] addr;
		logic [data_bits-1:0] data;
	} spi_frame_t;

	typedef union packed {
		spi_frame_t fields;
		logic [frame_bits-1:0] raw;
	} spi_frame_u;

	typedef struct packed {
		logic [addr_bits-1:0] addr;
		logic [data_bits-1:0] data;
	} spi_result_t;

	// Overrun sits in bit 3 so that writing bit 3 of the status word clears it.
	typedef struct packed {
		logic overrun;
		logic rd_valid;
		logic queue_full;
		logic busy;
	} bridge_status_t;

endpackage

`default_nettype wire

//--- rtl/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master import spi_reg_pkg::*; (
	input logic clk,
	input logic reset,
	input logic not_empty,
	input spi_frame_u head,
	output logic take,
	output logic busy,
	output logic result_valid,
	output spi_result_t result,
	output logic cs_n,
	output logic sck,
	output logic sdio_out,
	output logic sdio_oe,
	input logic sdio_in
);

	logic active; // Chip select is low.
	logic lead; // First half-period of the frame, sck held low.
	logic done;
	logic tick;
	logic rise;
	logic fall;
	logic last;
	logic [half_cnt_bits-1:0] half_cnt;
	logic [bit_cnt_bits-1:0] rise_cnt; // Rising edges issued so far.
	spi_frame_u cmd;
	spi_frame_u shreg;
	logic [data_bits-1:0] rx;

	assign take = ~busy & not_empty;
	assign tick = active & (half_cnt == '0);

	// Edge decode for the half-period that ends on this clock.
	assign rise = tick & ~lead & ~sck;
	assign last = tick & sck & (rise_cnt == bit_cnt_bits'(frame_bits));
	assign fall = tick & sck & ~last;

	assign sdio_out = shreg.raw[frame_bits-1]; // MSB first.

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			active <= 1'b0;
			lead <= 1'b0;
			done <= 1'b0;
			result_valid <= 1'b0;
			cs_n <= 1'b1;
			sck <= 1'b0;
			sdio_oe <= 1'b0;
			half_cnt <= '0;
			rise_cnt <= '0;
		end else begin
			result_valid <= done & cmd.fields.rw;
			done <= 1'b0;
			if (done) begin
				busy <= 1'b0;
			end
			if (take) begin
				busy <= 1'b1;
				active <= 1'b1;
				lead <= 1'b1;
				cs_n <= 1'b0;
				sdio_oe <= 1'b1;
				half_cnt <= half_cnt_bits'(sck_half);
				rise_cnt <= '0;
			end else if (active) begin
				half_cnt <= tick ? half_cnt_bits'(sck_half) : half_cnt - 1'b1;
				if (tick && lead) begin
					lead <= 1'b0;
				end
				if (rise) begin
					sck <= 1'b1;
					rise_cnt <= rise_cnt + 1'b1;
				end
				if (fall) begin
					sck <= 1'b0;
					// Turn the line around once rw and the address are out.
					if (cmd.fields.rw && rise_cnt == bit_cnt_bits'(addr_bits + 1)) begin
						sdio_oe <= 1'b0;
					end
				end
				if (last) begin
					sck <= 1'b0;
					cs_n <= 1'b1;
					sdio_oe <= 1'b0;
					active <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cmd <= head;
			shreg <= head;
		end else if (fall) begin
			shreg.raw <= {shreg.raw[frame_bits-2:0], 1'b0}; // Next bit on the falling edge.
		end
		if (rise && cmd.fields.rw && rise_cnt >= bit_cnt_bits'(addr_bits + 1)) begin
			rx <= {rx[data_bits-2:0], sdio_in};
		end
		if (done) begin
			result.addr <= cmd.fields.addr;
			result.data <= rx;
		end
	end

endmodule

`default_nettype wire

//--- rtl/spi_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_queue import spi_reg_pkg::*; (
	input logic clk,
	input logic reset,
	input logic push,
	input spi_frame_u push_frame,
	output logic full,
	output logic not_empty,
	output spi_frame_u head,
	input logic take
);

	spi_frame_u mem [queue_depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [count_bits-1:0] count;
	logic do_push;
	logic do_take;

	assign full = (count == count_bits'(queue_depth));
	assign not_empty = (count != '0);
	assign head = mem[rd_ptr];

	assign do_push = push & ~full; // Pushes while full are dropped here.
	assign do_take = take & not_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_bits'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_take) begin
				rd_ptr <= (rd_ptr == ptr_bits'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_take})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_frame;
		end
	end

endmodule

`default_nettype wire

//--- rtl/apb_spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_spi_regs import spi_reg_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	input logic psel,
	input logic penable,
	input logic pwrite,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic push,
	output spi_frame_u push_frame,
	input logic full,
	input logic busy,
	input logic result_valid,
	input spi_result_t result
);

	logic access;
	logic cmd_wr;
	logic status_wr;
	logic rdata_rd;
	logic rd_valid;
	logic overrun;
	spi_result_t result_q;
	bridge_status_t status;

	assign pready = 1'b1; // No wait states.
	assign access = psel & penable;

	assign cmd_wr = access & pwrite & (paddr == reg_cmd);
	assign status_wr = access & pwrite & (paddr == reg_status);
	assign rdata_rd = access & ~pwrite & (paddr == reg_rdata);

	// The queue's full flag is the only back-pressure on command writes.
	assign push = cmd_wr & ~full;
	assign push_frame.raw = pwdata[frame_bits-1:0];
	assign pslverr = cmd_wr & full;

	assign status.overrun = overrun;
	assign status.rd_valid = rd_valid;
	assign status.queue_full = full;
	assign status.busy = busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			if (result_valid) begin
				rd_valid <= 1'b1; // A new result wins over a read in the same cycle.
			end else if (rdata_rd) begin
				rd_valid <= 1'b0;
			end
			if (cmd_wr && full) begin
				overrun <= 1'b1;
			end else if (status_wr && pwdata[3]) begin
				overrun <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (result_valid) begin
			result_q <= result;
		end
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				reg_status: prdata = {{(32 - $bits(bridge_status_t)){1'b0}}, status};
				reg_rdata: prdata = {{(32 - $bits(spi_result_t)){1'b0}}, result_q};
				default: prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/spi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top import spi_reg_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [31:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic cs_n,
	output logic sck,
	output logic sdio_out,
	output logic sdio_oe,
	input logic sdio_in
);

	logic push;
	spi_frame_u push_frame;
	logic full;
	logic not_empty;
	spi_frame_u head;
	logic take;
	logic busy;
	logic result_valid;
	spi_result_t result;

	apb_spi_regs u_regs (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.pwdata(pwdata),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.push(push),
		.push_frame(push_frame),
		.full(full),
		.busy(busy),
		.result_valid(result_valid),
		.result(result)
	);

	spi_cmd_queue u_queue (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_frame(push_frame),
		.full(full),
		.not_empty(not_empty),
		.head(head),
		.take(take)
	);

	spi_master u_master (
		.clk(clk),
		.reset(reset),
		.not_empty(not_empty),
		.head(head),
		.take(take),
		.busy(busy),
		.result_valid(result_valid),
		.result(result),
		.cs_n(cs_n),
		.sck(sck),
		.sdio_out(sdio_out),
		.sdio_oe(sdio_oe),
		.sdio_in(sdio_in)
	);

endmodule

`default_nettype wire

//--- verif/spi_chip_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_chip_model (
	input wire cs_n,
	input wire sck,
	input wire sdio,
	output logic drive,
	output logic drive_bit,
	output int frames
);

	logic [7:0] mem [0:32767]; // One byte for every 15-bit register address.
	logic [15:0] header; // Read/write bit followed by the address.
	logic [7:0] wr_byte;
	logic [7:0] rd_byte;
	int count;

	initial begin
		for (int i = 0; i < 32768; i++) begin
			mem[i] = 8'h00;
		end
		header = '0;
		wr_byte = '0;
		rd_byte = '0;
		count = 0;
		drive = 1'b0;
		drive_bit = 1'b0;
		frames = 0;
	end

	always @(negedge cs_n) begin
		count = 0;
	end

	always @(posedge sck) begin
		if (cs_n === 1'b0) begin
			if (count < 16) begin
				header = {header[14:0], sdio};
			end else begin
				wr_byte = {wr_byte[6:0], sdio};
			end
			count = count + 1;
			if (count == 16) begin
				rd_byte = mem[header[14:0]];
			end
			if (count == 24 && !header[15]) begin
				mem[header[14:0]] = wr_byte;
			end
		end
	end

	// Read data changes on the falling edge, ahead of the master's sampling edge.
	always @(negedge sck) begin
		if (cs_n === 1'b0 && header[15] && count >= 16 && count < 24) begin
			drive = 1'b1;
			drive_bit = rd_byte[23 - count];
		end
	end

	always @(posedge cs_n) begin
		drive = 1'b0;
		if (count == 24) begin
			frames = frames + 1; // Only complete frames count.
		end
		count = 0;
	end

endmodule

`default_nettype wire

//--- verif/tb_spi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge import spi_reg_pkg::*; ();

	localparam int max_cycles = 20000;

	logic clk;
	logic reset;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic cs_n;
	logic sck;
	logic sdio_out;
	logic sdio_oe;
	logic model_drive;
	logic model_bit;
	wire sdio;
	int frames;
	int errors = 0;
	int cycles = 0;
	int rises = 0;
	logic in_frame = 1'b0;
	logic rd_frame = 1'b0;
	logic [31:0] rng = 32'h9645fc79;
	logic [7:0] scoreboard [0:32767];
	logic used [0:32767];

	// Pulled low when neither side drives.
	assign sdio = sdio_oe ? sdio_out : (model_drive ? model_bit : 1'b0);

	spi_bridge_top dut (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cs_n(cs_n),
		.sck(sck),
		.sdio_out(sdio_out),
		.sdio_oe(sdio_oe),
		.sdio_in(sdio)
	);

	spi_chip_model u_chip (
		.cs_n(cs_n),
		.sck(sck),
		.sdio(sdio),
		.drive(model_drive),
		.drive_bit(model_bit),
		.frames(frames)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic expect_true(input logic ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("FAILED at time %0t: %s", $time, msg);
		end
	endtask

	task automatic apb_access(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata; // Access phase, sampled mid-cycle.
		err = pslverr;
		expect_true(pready === 1'b1, "pready low in the access phase");
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic pick_address(output logic [14:0] addr);
		do begin
			rng = xorshift(rng);
			addr = rng[14:0];
		end while (used[addr]);
		used[addr] = 1'b1;
	endtask

	task automatic write_then_read(input logic [14:0] addr, input logic [7:0] data);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b1, reg_cmd, {8'h00, 1'b0, addr, data}, rdata, err);
		expect_true(!err, "write command rejected with an empty queue");
		scoreboard[addr] = data;
		apb_access(1'b1, reg_cmd, {8'h00, 1'b1, addr, 8'h00}, rdata, err);
		rdata = '0;
		while (!rdata[2]) begin
			apb_access(1'b0, reg_status, 32'h0, rdata, err); // Poll rd_valid.
		end
		apb_access(1'b0, reg_rdata, 32'h0, rdata, err);
		expect_true(rdata[22:8] == addr,
			$sformatf("result address %04h, expected %04h", rdata[22:8], addr));
		expect_true(rdata[7:0] == scoreboard[addr],
			$sformatf("read data %02h, expected %02h", rdata[7:0], scoreboard[addr]));
		apb_access(1'b0, reg_status, 32'h0, rdata, err);
		expect_true(!rdata[2], "rd_valid still set after reading reg_rdata");
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= max_cycles) begin
				$display("Timeout: the run did not finish within %0d cycles", max_cycles);
				$display("*** TEST FAILED ***");
				$finish;
			end
		end
	end

	// Frame shape, checked on every frame.
	always @(negedge cs_n) begin
		rises = 0;
		in_frame = 1'b1;
	end

	always @(posedge cs_n) begin
		if (in_frame) begin
			expect_true(rises == 24, $sformatf("frame held %0d sck rising edges", rises));
		end
		in_frame = 1'b0;
	end

	always @(posedge sck) begin
		expect_true(cs_n === 1'b0, "sck rose while cs_n was high");
		expect_true(!(sdio_oe && model_drive), "DUT and chip model drove sdio together");
		rises = rises + 1;
		if (rises == 1) begin
			rd_frame = sdio; // First bit on the line is rw.
		end
		expect_true(sdio_oe == !(rd_frame && rises > 16),
			$sformatf("sdio_oe %b at sck rising edge %0d", sdio_oe, rises));
	end

	initial begin
		logic [31:0] rdata;
		logic err;
		logic [14:0] addr;
		int accepted;
		int rejected;
		int base;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < 32768; i++) begin
			scoreboard[i] = 8'h00;
			used[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		expect_true(cs_n === 1'b1 && sck === 1'b0 && sdio_oe === 1'b0,
			"SPI pins not idle after reset");
		apb_access(1'b0, reg_status, 32'h0, rdata, err);
		expect_true(rdata == 32'h0, $sformatf("status %08h after reset", rdata));

		// One directed pair, then eight more to distinct addresses.
		for (int i = 0; i < 9; i++) begin
			pick_address(addr);
			rng = xorshift(rng);
			write_then_read(addr, rng[7:0]);
		end

		base = frames;
		pick_address(addr);
		rng = xorshift(rng);
		apb_access(1'b1, reg_cmd, {8'h00, 1'b0, addr, rng[7:0]}, rdata, err);
		scoreboard[addr] = rng[7:0];
		while (cs_n !== 1'b0) begin
			@(posedge clk);
		end
		apb_access(1'b0, reg_status, 32'h0, rdata, err);
		expect_true(rdata[0], "busy clear while a frame was active");
		accepted = 1;
		rejected = 0;
		for (int i = 0; i < queue_depth + 2; i++) begin
			pick_address(addr);
			rng = xorshift(rng);
			apb_access(1'b1, reg_cmd, {8'h00, 1'b0, addr, rng[7:0]}, rdata, err);
			if (err) begin
				rejected++;
			end else begin
				accepted++;
				scoreboard[addr] = rng[7:0];
			end
		end
		expect_true(rejected > 0, "no command write was rejected with a full queue");
		// One frame in flight plus a full queue behind it.
		expect_true(accepted == queue_depth + 1,
			$sformatf("%0d commands accepted, expected %0d", accepted, queue_depth + 1));
		apb_access(1'b0, reg_status, 32'h0, rdata, err);
		expect_true(rdata[3], "overrun not set after a rejected write");
		while (frames < base + accepted) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk); // busy falls one clock after cs_n rises.
		apb_access(1'b0, reg_status, 32'h0, rdata, err);
		expect_true(!rdata[0], "busy still set after all commands finished");
		apb_access(1'b1, reg_status, 32'h8, rdata, err);
		apb_access(1'b0, reg_status, 32'h0, rdata, err);
		expect_true(!rdata[3], "overrun not cleared by the status write");

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
rtl/spi_reg_pkg.sv
rtl/spi_master.sv
rtl/spi_cmd_queue.sv
rtl/apb_spi_regs.sv
rtl/spi_bridge_top.sv
verif/spi_chip_model.sv
verif/tb_spi_bridge.sv
